// ==== logic/paillier_pkg.sv ====
package paillier_pkg;

    localparam int WORD_W     = 32;            // Arithmetic word and bus width
    localparam int ADDR_W     = 3;             // Wishbone word address bits
    localparam int FIFO_DEPTH = 4;             // Queued votes
    localparam int ENTRY_W    = WORD_W + 1;    // Candidate bit on top of blinding word

    // Register map, word addresses
    localparam logic [ADDR_W-1:0] ADDR_N_SQUARED = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_K_CONST   = 3'd1;  // -(n^2)^-1 mod 2^32
    localparam logic [ADDR_W-1:0] ADDR_G_MONT    = 3'd2;  // (1+n)*2^32 mod n^2
    localparam logic [ADDR_W-1:0] ADDR_VOTE_0    = 3'd3;
    localparam logic [ADDR_W-1:0] ADDR_VOTE_1    = 3'd4;
    localparam logic [ADDR_W-1:0] ADDR_STATUS    = 3'd5;  // Bit 0 full, bit 1 busy

    // Encryptor FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_MULT = 2'd1;
    localparam logic [1:0] ST_HOLD = 2'd2;

endpackage

// ==== logic/wb_vote_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_vote_port (
    input wire clk_in,
    input wire rst_in,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_we,
    input wire [paillier_pkg::ADDR_W-1:0] wb_adr,
    input wire [paillier_pkg::WORD_W-1:0] wb_dat_w,
    output logic [paillier_pkg::WORD_W-1:0] wb_dat_r,
    output logic wb_ack,
    input wire full,
    input wire busy,
    output logic push,
    output logic [paillier_pkg::ENTRY_W-1:0] push_entry,
    output logic [paillier_pkg::WORD_W-1:0] n_squared,
    output logic [paillier_pkg::WORD_W-1:0] k_const,
    output logic [paillier_pkg::WORD_W-1:0] g_mont
);

logic req;          // Strobe not yet acknowledged
logic vote_addr;
logic vote_wr;
logic wr_commit;    // Write lands in the ack cycle

always_comb begin
    req       = wb_cyc && wb_stb && !wb_ack;
    vote_addr = (wb_adr == paillier_pkg::ADDR_VOTE_0) || (wb_adr == paillier_pkg::ADDR_VOTE_1);
    vote_wr   = wb_we && vote_addr;
    wr_commit = wb_cyc && wb_stb && wb_ack && wb_we;
    push      = wr_commit && vote_addr;
    // Candidate is carried by which vote address was hit
    push_entry = {(wb_adr == paillier_pkg::ADDR_VOTE_1), wb_dat_w};
end

// Vote writes wait while the queue has no room
always_ff @(posedge clk_in) begin
    if (rst_in) begin
        wb_ack <= 1'b0;
    end else begin
        wb_ack <= req && !(vote_wr && full);
    end
end

always_ff @(posedge clk_in) begin
    if (rst_in) begin
        n_squared <= '0;
        k_const   <= '0;
        g_mont    <= '0;
    end else if (wr_commit) begin
        case (wb_adr)
            paillier_pkg::ADDR_N_SQUARED: n_squared <= wb_dat_w;
            paillier_pkg::ADDR_K_CONST:   k_const   <= wb_dat_w;
            paillier_pkg::ADDR_G_MONT:    g_mont    <= wb_dat_w;
            default: ;                                  // Votes go to the queue
        endcase
    end
end

// Read data follows the held address
always_comb begin
    case (wb_adr)
        paillier_pkg::ADDR_N_SQUARED: wb_dat_r = n_squared;
        paillier_pkg::ADDR_K_CONST:   wb_dat_r = k_const;
        paillier_pkg::ADDR_G_MONT:    wb_dat_r = g_mont;
        paillier_pkg::ADDR_STATUS:    wb_dat_r = {{(paillier_pkg::WORD_W-2){1'b0}}, busy, full};
        default:                      wb_dat_r = '0;
    endcase
end

endmodule

`default_nettype wire

// ==== logic/vote_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module vote_fifo (
    input wire clk_in,
    input wire rst_in,
    input wire push,
    input wire [paillier_pkg::ENTRY_W-1:0] push_entry,
    input wire pop,
    output logic [paillier_pkg::ENTRY_W-1:0] pop_entry,
    output logic full,
    output logic empty
);

logic [paillier_pkg::ENTRY_W-1:0] mem [paillier_pkg::FIFO_DEPTH];
logic [$clog2(paillier_pkg::FIFO_DEPTH)-1:0] wr_ptr;
logic [$clog2(paillier_pkg::FIFO_DEPTH)-1:0] rd_ptr;
logic [$clog2(paillier_pkg::FIFO_DEPTH+1)-1:0] count;
logic do_push;
logic do_pop;

always_comb begin
    empty     = (count == '0);
    full      = (count == paillier_pkg::FIFO_DEPTH);
    do_pop    = pop && !empty;
    do_push   = push && (!full || do_pop);  // Room frees when popping at full
    pop_entry = mem[rd_ptr];                // First word falls through
end

always_ff @(posedge clk_in) begin
    if (do_push) begin
        mem[wr_ptr] <= push_entry;
    end
end

// Depth is a power of two so pointers wrap on their own
always_ff @(posedge clk_in) begin
    if (rst_in) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        if (do_push && !do_pop) begin
            count <= count + 1'b1;
        end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// ==== logic/montgomery_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module montgomery_multiplier (
    input wire clk_in,
    input wire rst_in,
    input wire start,
    input wire [paillier_pkg::WORD_W-1:0] operand,
    input wire [paillier_pkg::WORD_W-1:0] g_mont,
    input wire [paillier_pkg::WORD_W-1:0] n_squared,
    input wire [paillier_pkg::WORD_W-1:0] k_const,
    output logic [paillier_pkg::WORD_W-1:0] product,
    output logic done
);

logic [2*paillier_pkg::WORD_W-1:0] t_reg;      // Full product, stage 1
logic [paillier_pkg::WORD_W:0]     u_word;     // (T + m*n^2) / R, stage 2
logic [paillier_pkg::WORD_W-1:0]   m_word;
logic [2*paillier_pkg::WORD_W:0]   sum_next;
logic [paillier_pkg::WORD_W:0]     u_diff;
logic valid_1;
logic valid_2;

always_comb begin
    // Only the low word of m matters modulo R
    m_word   = t_reg[paillier_pkg::WORD_W-1:0] * k_const;
    sum_next = {1'b0, t_reg}
             + {{(paillier_pkg::WORD_W+1){1'b0}}, m_word}
             * {{(paillier_pkg::WORD_W+1){1'b0}}, n_squared};
    u_diff   = u_word - {1'b0, n_squared};
end

always_ff @(posedge clk_in) begin
    if (start) begin
        t_reg <= {{paillier_pkg::WORD_W{1'b0}}, operand}
               * {{paillier_pkg::WORD_W{1'b0}}, g_mont};
    end
    if (valid_1) begin
        // Low word is zero by construction
        u_word <= sum_next[2*paillier_pkg::WORD_W:paillier_pkg::WORD_W];
    end
    if (valid_2) begin
        // u < 2*n^2, one subtraction is enough
        if (u_word >= {1'b0, n_squared}) begin
            product <= u_diff[paillier_pkg::WORD_W-1:0];
        end else begin
            product <= u_word[paillier_pkg::WORD_W-1:0];
        end
    end
end

always_ff @(posedge clk_in) begin
    if (rst_in) begin
        valid_1 <= 1'b0;
        valid_2 <= 1'b0;
        done    <= 1'b0;
    end else begin
        valid_1 <= start;
        valid_2 <= valid_1;
        done    <= valid_2;     // Three cycles after start
    end
end

endmodule

`default_nettype wire

// ==== logic/candidate_encryptor.sv ====
`timescale 1ns/1ps
`default_nettype none

module candidate_encryptor (
    input wire clk_in,
    input wire rst_in,
    input wire empty,
    input wire [paillier_pkg::ENTRY_W-1:0] pop_entry,
    output logic pop,
    input wire [paillier_pkg::WORD_W-1:0] n_squared,
    input wire [paillier_pkg::WORD_W-1:0] k_const,
    input wire [paillier_pkg::WORD_W-1:0] g_mont,
    output logic busy,
    output logic [paillier_pkg::WORD_W-1:0] cipher_data,
    output logic cipher_valid,
    input wire cipher_ready
);

logic [1:0] state;
logic candidate;
logic mult_start;
logic [paillier_pkg::WORD_W-1:0] mult_product;
logic mult_done;

always_comb begin
    candidate  = pop_entry[paillier_pkg::ENTRY_W-1];
    pop        = (state == paillier_pkg::ST_IDLE) && !empty;
    mult_start = pop && candidate;      // Launch straight off the queue head
    busy       = (state != paillier_pkg::ST_IDLE);
end

montgomery_multiplier vote_1_caster (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start(mult_start),
    .operand(pop_entry[paillier_pkg::WORD_W-1:0]),
    .g_mont(g_mont),
    .n_squared(n_squared),
    .k_const(k_const),
    .product(mult_product),
    .done(mult_done)
);

// Output register keeps the word stable under back-pressure
always_ff @(posedge clk_in) begin
    if (pop && !candidate) begin
        cipher_data <= pop_entry[paillier_pkg::WORD_W-1:0];   // Vote 0 passes as is
    end else if (state == paillier_pkg::ST_MULT && mult_done) begin
        cipher_data <= mult_product;
    end
end

always_ff @(posedge clk_in) begin
    if (rst_in) begin
        state        <= paillier_pkg::ST_IDLE;
        cipher_valid <= 1'b0;
    end else begin
        case (state)
            paillier_pkg::ST_IDLE: begin
                if (pop && candidate) begin
                    state <= paillier_pkg::ST_MULT;
                end else if (pop) begin
                    state        <= paillier_pkg::ST_HOLD;
                    cipher_valid <= 1'b1;
                end
            end
            paillier_pkg::ST_MULT: begin
                if (mult_done) begin
                    state        <= paillier_pkg::ST_HOLD;
                    cipher_valid <= 1'b1;
                end
            end
            paillier_pkg::ST_HOLD: begin
                if (cipher_ready) begin     // Word taken this cycle
                    state        <= paillier_pkg::ST_IDLE;
                    cipher_valid <= 1'b0;
                end
            end
            default: begin
                state        <= paillier_pkg::ST_IDLE;
                cipher_valid <= 1'b0;
            end
        endcase
    end
end

endmodule

`default_nettype wire

// ==== logic/paillier_vote_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module paillier_vote_top (
    input wire clk_in,
    input wire rst_in,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_we,
    input wire [paillier_pkg::ADDR_W-1:0] wb_adr,
    input wire [paillier_pkg::WORD_W-1:0] wb_dat_w,
    output logic [paillier_pkg::WORD_W-1:0] wb_dat_r,
    output logic wb_ack,
    output logic [paillier_pkg::WORD_W-1:0] cipher_data,
    output logic cipher_valid,
    input wire cipher_ready
);

logic push;
logic [paillier_pkg::ENTRY_W-1:0] push_entry;
logic pop;
logic [paillier_pkg::ENTRY_W-1:0] pop_entry;
logic full;
logic empty;
logic busy;
logic [paillier_pkg::WORD_W-1:0] n_squared;
logic [paillier_pkg::WORD_W-1:0] k_const;
logic [paillier_pkg::WORD_W-1:0] g_mont;

wb_vote_port vote_port (                    // Producer
    .clk_in(clk_in),
    .rst_in(rst_in),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack),
    .full(full),
    .busy(busy),
    .push(push),
    .push_entry(push_entry),
    .n_squared(n_squared),
    .k_const(k_const),
    .g_mont(g_mont)
);

vote_fifo vote_queue (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .push(push),
    .push_entry(push_entry),
    .pop(pop),
    .pop_entry(pop_entry),
    .full(full),
    .empty(empty)
);

candidate_encryptor encryptor (             // Consumer
    .clk_in(clk_in),
    .rst_in(rst_in),
    .empty(empty),
    .pop_entry(pop_entry),
    .pop(pop),
    .n_squared(n_squared),
    .k_const(k_const),
    .g_mont(g_mont),
    .busy(busy),
    .cipher_data(cipher_data),
    .cipher_valid(cipher_valid),
    .cipher_ready(cipher_ready)
);

endmodule

`default_nettype wire

// ==== verif/tb_paillier_vote.sv ====
`timescale 1ns/1ps

module tb_paillier_vote;

logic clk_in;
logic rst_in;
logic wb_cyc;
logic wb_stb;
logic wb_we;
logic [paillier_pkg::ADDR_W-1:0] wb_adr;
logic [paillier_pkg::WORD_W-1:0] wb_dat_w;
logic [paillier_pkg::WORD_W-1:0] wb_dat_r;
logic wb_ack;
logic [paillier_pkg::WORD_W-1:0] cipher_data;
logic cipher_valid;
logic cipher_ready;

logic [31:0] expected_q[$];     // Ciphertexts still owed by the DUT
logic [31:0] exp_word;
logic [31:0] lcg_state;
logic [63:0] n_cur;
logic [63:0] n2_cur;
int errors;
int errors_at_start;
int tests_ok;
int tests_bad;
string test_name;

paillier_vote_top DUT (.*);

initial clk_in = 1'b0;
always #2 clk_in = ~clk_in;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [31:0] random_blind();
    logic [63:0] wide;
    wide = {32'd0, lcg_next()} % n2_cur;    // Blinding value below n^2
    return wide[31:0];
endfunction

// Each Newton step doubles the number of correct low bits
function automatic logic [31:0] neg_inverse(input logic [31:0] a);
    logic [31:0] x;
    x = a;                                  // Already right to 3 bits for odd a
    repeat (5) begin
        x = x * (32'd2 - a * x);
    end
    return -x;
endfunction

function automatic logic [31:0] generator_mont_form();
    logic [63:0] wide;
    wide = ((n_cur + 64'd1) << 32) % n2_cur;    // (1+n)*R mod n^2
    return wide[31:0];
endfunction

function automatic logic [31:0] expected_cipher(input logic candidate, input logic [31:0] blind);
    logic [63:0] wide;
    wide = {32'd0, blind};
    if (candidate) begin
        wide = (wide * (n_cur + 64'd1)) % n2_cur;  // Times g = 1 + n
    end
    return wide[31:0];
endfunction

task automatic start_cycle(input logic [paillier_pkg::ADDR_W-1:0] adr, input logic we,
                           input logic [31:0] dat);
    @(posedge clk_in);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
endtask

task automatic wait_for_ack(input int limit, output logic acked);
    int cycles;
    cycles = 0;
    acked  = 1'b0;
    while (!acked && cycles < limit) begin
        @(posedge clk_in);
        #1;
        acked  = wb_ack;
        cycles = cycles + 1;
    end
endtask

task automatic end_cycle();
    @(posedge clk_in);                      // Ack cycle ends here
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic access(input logic [paillier_pkg::ADDR_W-1:0] adr, input logic we,
                      input logic [31:0] dat, output logic [31:0] data);
    logic acked;
    start_cycle(adr, we, dat);
    wait_for_ack(20, acked);
    data = wb_dat_r;
    end_cycle();
    assert (acked) else begin
        $display("No ack from address %0d in %s", adr, test_name);
        errors++;
    end
endtask

task automatic check_read(input logic [paillier_pkg::ADDR_W-1:0] adr, input logic [31:0] expected);
    logic [31:0] data;
    access(adr, 1'b0, 32'd0, data);
    assert (data == expected) else begin
        $display("Mismatch in %s: address %0d expected %h, actual %h",
                 test_name, adr, expected, data);
        errors++;
    end
endtask

task automatic load_keys(input logic [63:0] n);
    logic [31:0] unused;
    n_cur  = n;
    n2_cur = n * n;
    access(paillier_pkg::ADDR_N_SQUARED, 1'b1, n2_cur[31:0], unused);
    access(paillier_pkg::ADDR_K_CONST, 1'b1, neg_inverse(n2_cur[31:0]), unused);
    access(paillier_pkg::ADDR_G_MONT, 1'b1, generator_mont_form(), unused);
endtask

task automatic submit_vote(input logic candidate, input logic [31:0] blind);
    logic [31:0] unused;
    expected_q.push_back(expected_cipher(candidate, blind));
    access(candidate ? paillier_pkg::ADDR_VOTE_1 : paillier_pkg::ADDR_VOTE_0, 1'b1, blind, unused);
endtask

task automatic drain_ciphers(input int limit);
    int cycles;
    cycles = 0;
    while (expected_q.size() > 0 && cycles < limit) begin
        @(posedge clk_in);
        #1;
        cycles = cycles + 1;
    end
    assert (expected_q.size() == 0) else begin
        $display("Timeout in %s: %0d ciphertexts never arrived", test_name, expected_q.size());
        errors++;
        expected_q.delete();
    end
endtask

task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
endtask

task automatic finish_test();
    if (errors == errors_at_start) begin
        tests_ok++;
        $display("%s: ok", test_name);
    end else begin
        tests_bad++;
        $display("%s: FAILED with %0d errors", test_name, errors - errors_at_start);
    end
endtask

// One transfer per cycle, judged mid-cycle where data is settled
always @(negedge clk_in) begin
    if (!rst_in && cipher_valid && cipher_ready) begin
        assert (expected_q.size() > 0) else begin
            $display("Unexpected ciphertext %h in %s", cipher_data, test_name);
            errors++;
        end
        if (expected_q.size() > 0) begin
            exp_word = expected_q.pop_front();
            assert (cipher_data == exp_word) else begin
                $display("Mismatch in %s: expected %h, actual %h", test_name, exp_word, cipher_data);
                errors++;
            end
        end
    end
end

initial begin
    logic acked;
    logic [31:0] pick;
    logic [31:0] blind;
    rst_in       = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    cipher_ready = 1'b1;
    errors       = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    lcg_state    = 32'd23;
    n_cur        = 64'd0;
    n2_cur       = 64'd1;
    test_name    = "reset";
    repeat (8) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    begin_test("key_registers");
    check_read(paillier_pkg::ADDR_STATUS, 32'd0);
    load_keys(64'd251);
    check_read(paillier_pkg::ADDR_N_SQUARED, n2_cur[31:0]);
    check_read(paillier_pkg::ADDR_K_CONST, neg_inverse(n2_cur[31:0]));
    check_read(paillier_pkg::ADDR_G_MONT, generator_mont_form());
    finish_test();

    begin_test("candidate_0");
    repeat (6) submit_vote(1'b0, random_blind());
    drain_ciphers(100);
    finish_test();

    begin_test("candidate_1");
    repeat (2) begin
        submit_vote(1'b1, 32'd1);
        submit_vote(1'b1, n2_cur[31:0] - 32'd1);
        repeat (5) submit_vote(1'b1, random_blind());
        drain_ciphers(200);
        load_keys(64'd65521);               // n^2 just below 2^32
    end
    finish_test();

    begin_test("random_stream");
    repeat (40) begin
        pick = lcg_next();
        submit_vote(pick[31], random_blind());
    end
    drain_ciphers(400);
    finish_test();

    begin_test("back_pressure");
    cipher_ready = 1'b0;
    repeat (5) begin
        pick = lcg_next();
        submit_vote(pick[31], random_blind());
    end
    check_read(paillier_pkg::ADDR_STATUS, 32'd3);  // Queue full, encryptor busy
    blind = random_blind();
    expected_q.push_back(expected_cipher(1'b1, blind));
    start_cycle(paillier_pkg::ADDR_VOTE_1, 1'b1, blind);
    wait_for_ack(20, acked);
    assert (!acked) else begin
        $display("Vote write in %s was acknowledged while the queue was full", test_name);
        errors++;
    end
    cipher_ready = 1'b1;
    wait_for_ack(100, acked);
    assert (acked) else begin
        $display("Stalled vote in %s got no ack after the stream was released", test_name);
        errors++;
    end
    end_cycle();
    drain_ciphers(200);
    repeat (10) @(posedge clk_in);          // Room for any duplicate to show up
    finish_test();

    $display("Tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

// ==== flist.f ====
logic/paillier_pkg.sv
logic/wb_vote_port.sv
logic/vote_fifo.sv
logic/montgomery_multiplier.sv
logic/candidate_encryptor.sv
logic/paillier_vote_top.sv
verif/tb_paillier_vote.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_paillier_vote -f flist.f \
    && ./obj_dir/Vtb_paillier_vote > sim.log 2>&1 \
    || { echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
